/* filelist.f */
rtl/decodePkg.sv
rtl/ctrlBus.sv
rtl/mainDecoder.sv
rtl/aluFuncDecoder.sv
rtl/decodeStage.sv
rtl/instrDecodeTop.sv
verif/instrDecodeTb.sv

/* run.sh */
#!/bin/sh
# Compile and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 \
    --top-module instrDecodeTb \
    -f filelist.f \
    -o simv
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/simv
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation ended with status $status"
    exit $status
fi

exit 0

/* verif/instrDecodeTb.sv */
`timescale 1ns/1ps

module instrDecodeTb;
    import decodePkg::*;

    localparam int DataWidth     = 32;
    localparam int StreamLength  = 100;
    localparam int TimeoutCycles = 2000;  // About ten times the total test length

    typedef struct packed {
        logic                 regWrite;
        logic                 aluSrc;
        logic                 memRead;
        logic                 memWrite;
        logic                 memToReg;
        memSize_t             memSize;
        logic                 jump;
        logic                 illegal;
        aluOp_t               aluOp;
        logic [4:0]           writeReg;
        logic [DataWidth-1:0] immExt;
    } expected_t;

    logic                 clk;
    logic                 rstN;
    logic                 instrValid;
    logic [31:0]          instr;
    logic                 outValid;
    logic                 regWrite;
    logic                 aluSrc;
    logic                 memRead;
    logic                 memWrite;
    logic                 memToReg;
    memSize_t             memSize;
    logic                 jump;
    logic                 illegal;
    aluOp_t               aluOp;
    logic [4:0]           writeReg;
    logic [DataWidth-1:0] immExt;
    int                   cycleCount = 0;
    int                   seedInit;

    instrDecodeTop #(.DataWidth(DataWidth)) uut (
        .clk(clk), .rstN(rstN), .instrValid(instrValid), .instr(instr),
        .outValid(outValid), .regWrite(regWrite), .aluSrc(aluSrc),
        .memRead(memRead), .memWrite(memWrite), .memToReg(memToReg),
        .memSize(memSize), .jump(jump), .illegal(illegal), .aluOp(aluOp),
        .writeReg(writeReg), .immExt(immExt)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TimeoutCycles) begin
            $display("Verification failed");
            $fatal(1, "Timeout, the run went past %0d clock cycles", TimeoutCycles);
        end
    end

    task automatic checkValue(input string testName, input string field,
                              input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("** Error [%s] %s: expected 0x%0h, actual 0x%0h",
                     testName, field, expected, actual);
            $display("Verification failed");
            $fatal(1, "Output mismatch in test %s", testName);
        end
    endtask

    // Expected outputs built from the decode rules
    function automatic expected_t predict(input logic [31:0] ins);
        expected_t  e;
        logic [5:0] op;
        logic [5:0] fn;
        logic       signExt;
        e = '0;
        op = ins[31:26];
        fn = ins[5:0];
        signExt = 1'b0;
        e.aluOp = AluAdd;
        e.memSize = MemWord;
        e.writeReg = ins[20:16];
        case (op)
            OpSpecial: begin
                e.regWrite = 1'b1;
                e.writeReg = ins[15:11];
                case (fn)
                    FnAdd:   e.aluOp = AluAdd;
                    FnAddu:  e.aluOp = AluAddu;
                    FnSub:   e.aluOp = AluSub;
                    FnSubu:  e.aluOp = AluSubu;
                    FnAnd:   e.aluOp = AluAnd;
                    FnOr:    e.aluOp = AluOr;
                    FnXor:   e.aluOp = AluXor;
                    FnNor:   e.aluOp = AluNor;
                    FnSlt:   e.aluOp = AluSlt;
                    FnSltu:  e.aluOp = AluSltu;
                    FnSll:   e.aluOp = AluSll;
                    FnSrl:   e.aluOp = AluSrl;
                    FnSra:   e.aluOp = AluSra;
                    default: e.illegal = 1'b1;
                endcase
            end
            OpSpecial2, OpSpecial3: begin
                e.regWrite = 1'b1;
                e.writeReg = ins[15:11];
                if (op == OpSpecial2 && fn == FnMul) e.aluOp = AluMul;
                else if (op == OpSpecial3 && fn == FnBshfl && ins[10:6] == SaSeb) e.aluOp = AluSeb;
                else if (op == OpSpecial3 && fn == FnBshfl && ins[10:6] == SaSeh) e.aluOp = AluSeh;
                else e.illegal = 1'b1;
            end
            OpAddi, OpAddiu, OpSlti, OpSltiu, OpAndi, OpOri, OpXori: begin
                e.regWrite = 1'b1;
                e.aluSrc = 1'b1;
                signExt = !(op == OpAndi || op == OpOri || op == OpXori);
                case (op)
                    OpAddi:  e.aluOp = AluAdd;
                    OpAddiu: e.aluOp = AluAddu;
                    OpSlti:  e.aluOp = AluSlt;
                    OpSltiu: e.aluOp = AluSltu;
                    OpAndi:  e.aluOp = AluAnd;
                    OpOri:   e.aluOp = AluOr;
                    default: e.aluOp = AluXor;
                endcase
            end
            OpLb, OpLh, OpLw, OpSb, OpSh, OpSw: begin
                e.aluSrc = 1'b1;
                e.aluOp = AluAddu;  // Base plus offset
                signExt = 1'b1;
                e.memRead = (op == OpLb || op == OpLh || op == OpLw);
                e.memToReg = e.memRead;
                e.regWrite = e.memRead;
                e.memWrite = !e.memRead;
                if (op == OpLb || op == OpSb) e.memSize = MemByte;
                else if (op == OpLh || op == OpSh) e.memSize = MemHalf;
            end
            OpJ: e.jump = 1'b1;
            OpJal: begin
                e.jump = 1'b1;
                e.regWrite = 1'b1;
                e.writeReg = LinkReg;
            end
            default: e.illegal = 1'b1;
        endcase
        if (signExt && ins[15]) e.immExt = '1;  // Upper bits all ones for a negative field
        e.immExt[15:0] = ins[15:0];
        if (e.illegal) begin
            e.regWrite = 1'b0;
            e.memRead = 1'b0;
            e.memWrite = 1'b0;
            e.jump = 1'b0;
        end
        return e;
    endfunction

    // Kinds 0-15 register ops, 16-22 immediates, 23-28 loads and stores, 29-30 jumps
    function automatic logic [31:0] legalInstr(input int kind, input logic immTop);
        logic [31:0] r;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  sa;
        logic [5:0]  op;
        r = $urandom;
        rs = r[4:0];
        rt = r[9:5];
        rd = r[14:10];
        sa = r[19:15];
        op = OpAddi;
        case (kind)
            0:  return {OpSpecial, rs, rt, rd, sa, FnAdd};
            1:  return {OpSpecial, rs, rt, rd, sa, FnAddu};
            2:  return {OpSpecial, rs, rt, rd, sa, FnSub};
            3:  return {OpSpecial, rs, rt, rd, sa, FnSubu};
            4:  return {OpSpecial, rs, rt, rd, sa, FnAnd};
            5:  return {OpSpecial, rs, rt, rd, sa, FnOr};
            6:  return {OpSpecial, rs, rt, rd, sa, FnXor};
            7:  return {OpSpecial, rs, rt, rd, sa, FnNor};
            8:  return {OpSpecial, rs, rt, rd, sa, FnSlt};
            9:  return {OpSpecial, rs, rt, rd, sa, FnSltu};
            10: return {OpSpecial, rs, rt, rd, sa, FnSll};
            11: return {OpSpecial, rs, rt, rd, sa, FnSrl};
            12: return {OpSpecial, rs, rt, rd, sa, FnSra};
            13: return {OpSpecial2, rs, rt, rd, 5'd0, FnMul};
            14: return {OpSpecial3, 5'd0, rt, rd, SaSeb, FnBshfl};
            15: return {OpSpecial3, 5'd0, rt, rd, SaSeh, FnBshfl};
            16: op = OpAddi;
            17: op = OpAddiu;
            18: op = OpSlti;
            19: op = OpSltiu;
            20: op = OpAndi;
            21: op = OpOri;
            22: op = OpXori;
            23: op = OpLb;
            24: op = OpLh;
            25: op = OpLw;
            26: op = OpSb;
            27: op = OpSh;
            28: op = OpSw;
            29: return {OpJ, r[25:0]};
            30: return {OpJal, r[31:6]};
            default: op = OpAddi;
        endcase
        return {op, rs, rt, immTop, r[30:16]};
    endfunction

    task automatic checkDecoded(input string testName, input expected_t e);
        checkValue(testName, "outValid", 32'(1'b1), 32'(outValid));
        checkValue(testName, "regWrite", 32'(e.regWrite), 32'(regWrite));
        checkValue(testName, "memRead", 32'(e.memRead), 32'(memRead));
        checkValue(testName, "memWrite", 32'(e.memWrite), 32'(memWrite));
        checkValue(testName, "jump", 32'(e.jump), 32'(jump));
        checkValue(testName, "illegal", 32'(e.illegal), 32'(illegal));
        if (!e.illegal) begin
            checkValue(testName, "aluSrc", 32'(e.aluSrc), 32'(aluSrc));
            checkValue(testName, "memToReg", 32'(e.memToReg), 32'(memToReg));
            checkValue(testName, "aluOp", 32'(e.aluOp), 32'(aluOp));
            checkValue(testName, "immExt", 32'(e.immExt), 32'(immExt));
            if (e.regWrite) checkValue(testName, "writeReg", 32'(e.writeReg), 32'(writeReg));
            if (e.memRead || e.memWrite) begin
                checkValue(testName, "memSize", 32'(e.memSize), 32'(memSize));
            end
        end
    endtask

    // One strobe, result checked one cycle later
    task automatic applyOne(input string testName, input logic [31:0] ins);
        expected_t e;
        e = predict(ins);
        @(posedge clk);
        instrValid <= 1'b1;
        instr <= ins;
        @(posedge clk);
        instrValid <= 1'b0;
        @(negedge clk);
        checkDecoded(testName, e);
    endtask

    task automatic testResetIdle();
        repeat (8) begin
            @(negedge clk);
            checkValue("resetIdle", "outValid", 32'(1'b0), 32'(outValid));
            checkValue("resetIdle", "regWrite", 32'(1'b0), 32'(regWrite));
            checkValue("resetIdle", "memRead", 32'(1'b0), 32'(memRead));
            checkValue("resetIdle", "memWrite", 32'(1'b0), 32'(memWrite));
            checkValue("resetIdle", "jump", 32'(1'b0), 32'(jump));
            checkValue("resetIdle", "illegal", 32'(1'b0), 32'(illegal));
        end
    endtask

    task automatic testRegisterOps();
        for (int k = 0; k <= 15; k++) applyOne("registerOps", legalInstr(k, 1'b0));
    endtask

    task automatic testImmediateOps();
        for (int k = 16; k <= 22; k++) begin
            applyOne("immediateOps", legalInstr(k, 1'b0));
            applyOne("immediateOps", legalInstr(k, 1'b1));  // Negative immediate
        end
    endtask

    task automatic testMemoryAndJumps();
        for (int k = 23; k <= 30; k++) applyOne("memoryAndJumps", legalInstr(k, k[0]));
    endtask

    task automatic testIllegal();
        logic [31:0] r;
        r = $urandom;
        applyOne("illegal", {6'b000100, r[25:0]});  // BEQ
        applyOne("illegal", {6'b001111, r[25:0]});  // LUI
        applyOne("illegal", {OpSpecial, r[25:6], 6'b001000});  // JR
        applyOne("illegal", {OpSpecial, r[25:6], 6'b000001});
        applyOne("illegal", {OpSpecial, r[25:6], 6'b111111});
    endtask

    task automatic testStream();
        expected_t   pending[$];
        expected_t   e;
        logic [31:0] ins;
        logic [31:0] r;
        for (int i = 0; i <= StreamLength; i++) begin
            @(posedge clk);
            if (i < StreamLength) begin
                r = $urandom;
                ins = legalInstr(int'(r % 32'd31), r[31]);
                pending.push_back(predict(ins));
                instrValid <= 1'b1;
                instr <= ins;
            end else begin
                instrValid <= 1'b0;
            end
            @(negedge clk);
            if (i == 0) begin
                checkValue("stream", "outValid", 32'(1'b0), 32'(outValid));
            end else begin
                e = pending.pop_front();
                checkDecoded("stream", e);
            end
        end
        @(negedge clk);
        checkValue("stream", "outValid after stream", 32'(1'b0), 32'(outValid));
    endtask

    initial begin
        seedInit = $urandom(32'h5bef_b381);
        rstN = 1'b0;
        instrValid = 1'b0;
        instr = '0;
        repeat (16) @(posedge clk);
        rstN <= 1'b1;
        testResetIdle();
        testRegisterOps();
        testImmediateOps();
        testMemoryAndJumps();
        testIllegal();
        testStream();
        $display("Verification passed");
        $finish;
    end

endmodule

/* rtl/instrDecodeTop.sv */
`timescale 1ns/1ps

module instrDecodeTop #(
    parameter int DataWidth = 32
) (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   instrValid,
    input  logic [31:0]            instr,
    output logic                   outValid,
    output logic                   regWrite,
    output logic                   aluSrc,
    output logic                   memRead,
    output logic                   memWrite,
    output logic                   memToReg,
    output decodePkg::memSize_t    memSize,
    output logic                   jump,
    output logic                   illegal,
    output decodePkg::aluOp_t      aluOp,
    output logic [4:0]             writeReg,
    output logic [DataWidth-1:0]   immExt
);
    import decodePkg::*;

    aluOp_t decAluOp;     // From function decoder
    logic   funcIllegal;

    ctrlBus ctrl ();

    mainDecoder uMainDec (
        .opcode (instr[31:26]),
        .ctrl   (ctrl.source)
    );

    aluFuncDecoder uAluDec (
        .opcode      (instr[31:26]),
        .funct       (instr[5:0]),
        .shamt       (instr[10:6]),
        .aluOp       (decAluOp),
        .funcIllegal (funcIllegal)
    );

    decodeStage #(
        .DataWidth (DataWidth)
    ) uStage (
        .clk         (clk),
        .rstN        (rstN),
        .instrValid  (instrValid),
        .rt          (instr[20:16]),
        .rd          (instr[15:11]),
        .imm         (instr[15:0]),
        .ctrl        (ctrl.sink),
        .aluOp       (decAluOp),
        .funcIllegal (funcIllegal),
        .outValid    (outValid),
        .regWrite    (regWrite),
        .aluSrc      (aluSrc),
        .memRead     (memRead),
        .memWrite    (memWrite),
        .memToReg    (memToReg),
        .memSize     (memSize),
        .jump        (jump),
        .illegal     (illegal),
        .aluOpOut    (aluOp),
        .writeReg    (writeReg),
        .immExt      (immExt)
    );

endmodule

/* rtl/decodeStage.sv */
`timescale 1ns/1ps

module decodeStage #(
    parameter int DataWidth = 32
) (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   instrValid,
    input  logic [4:0]             rt,
    input  logic [4:0]             rd,
    input  logic [15:0]            imm,
    ctrlBus.sink                   ctrl,
    input  decodePkg::aluOp_t      aluOp,
    input  logic                   funcIllegal,
    output logic                   outValid,
    output logic                   regWrite,
    output logic                   aluSrc,
    output logic                   memRead,
    output logic                   memWrite,
    output logic                   memToReg,
    output decodePkg::memSize_t    memSize,
    output logic                   jump,
    output logic                   illegal,
    output decodePkg::aluOp_t      aluOpOut,
    output logic [4:0]             writeReg,
    output logic [DataWidth-1:0]   immExt
);
    import decodePkg::*;

    logic                 illegalNext;
    logic [4:0]           writeRegNext;
    logic [DataWidth-1:0] immExtNext;

    assign illegalNext = ctrl.opIllegal | funcIllegal;

    always_comb begin
        case (ctrl.regDst)
            DstRd:   writeRegNext = rd;
            DstLink: writeRegNext = LinkReg;
            default: writeRegNext = rt;
        endcase
    end

    // Sign or zero extension of the 16-bit field
    assign immExtNext = ctrl.signExt ? {{(DataWidth-16){imm[15]}}, imm}
                                     : {{(DataWidth-16){1'b0}}, imm};

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            outValid <= 1'b0;
            regWrite <= 1'b0;
            aluSrc   <= 1'b0;
            memRead  <= 1'b0;
            memWrite <= 1'b0;
            memToReg <= 1'b0;
            memSize  <= MemByte;
            jump     <= 1'b0;
            illegal  <= 1'b0;
            aluOpOut <= AluAdd;
            writeReg <= '0;
            immExt   <= '0;
        end else begin
            outValid <= instrValid;  // One-cycle strobe, delayed
            if (instrValid) begin
                // Side effects are suppressed for illegal instructions
                regWrite <= ctrl.regWrite & ~illegalNext;
                memRead  <= ctrl.memRead & ~illegalNext;
                memWrite <= ctrl.memWrite & ~illegalNext;
                jump     <= ctrl.jump & ~illegalNext;
                aluSrc   <= ctrl.aluSrc;
                memToReg <= ctrl.memToReg;
                memSize  <= ctrl.memSize;
                illegal  <= illegalNext;
                aluOpOut <= aluOp;
                writeReg <= writeRegNext;
                immExt   <= immExtNext;
            end
        end
    end

endmodule

/* rtl/aluFuncDecoder.sv */
`timescale 1ns/1ps

module aluFuncDecoder (
    input  logic [5:0]       opcode,
    input  logic [5:0]       funct,
    input  logic [4:0]       shamt,
    output decodePkg::aluOp_t aluOp,
    output logic             funcIllegal
);
    import decodePkg::*;

    always_comb begin
        aluOp       = AluAdd;
        funcIllegal = 1'b0;

        case (opcode)
            OpSpecial: begin
                case (funct)
                    FnAdd:   aluOp = AluAdd;
                    FnAddu:  aluOp = AluAddu;
                    FnSub:   aluOp = AluSub;
                    FnSubu:  aluOp = AluSubu;
                    FnAnd:   aluOp = AluAnd;
                    FnOr:    aluOp = AluOr;
                    FnXor:   aluOp = AluXor;
                    FnNor:   aluOp = AluNor;
                    FnSlt:   aluOp = AluSlt;
                    FnSltu:  aluOp = AluSltu;
                    FnSll:   aluOp = AluSll;
                    FnSrl:   aluOp = AluSrl;
                    FnSra:   aluOp = AluSra;
                    default: funcIllegal = 1'b1;  // JR among others
                endcase
            end

            OpSpecial2: begin
                if (funct == FnMul) aluOp = AluMul;
                else                funcIllegal = 1'b1;
            end

            OpSpecial3: begin
                // BSHFL picks its op from shamt
                if (funct == FnBshfl && shamt == SaSeb) begin
                    aluOp = AluSeb;
                end else if (funct == FnBshfl && shamt == SaSeh) begin
                    aluOp = AluSeh;
                end else begin
                    funcIllegal = 1'b1;
                end
            end

            OpAddi:  aluOp = AluAdd;
            OpAddiu: aluOp = AluAddu;
            OpSlti:  aluOp = AluSlt;
            OpSltiu: aluOp = AluSltu;
            OpAndi:  aluOp = AluAnd;
            OpOri:   aluOp = AluOr;
            OpXori:  aluOp = AluXor;

            OpLb, OpLh, OpLw, OpSb, OpSh, OpSw: begin
                aluOp = AluAddu;  // Address calculation
            end

            OpJ, OpJal: aluOp = AluAdd;

            // Unknown opcodes are flagged by the main decoder
            default: aluOp = AluAdd;
        endcase
    end

endmodule

/* rtl/mainDecoder.sv */
`timescale 1ns/1ps

module mainDecoder (
    input  logic [5:0]    opcode,
    ctrlBus.source        ctrl
);
    import decodePkg::*;

    always_comb begin
        // Defaults describe a harmless no-op
        ctrl.regWrite  = 1'b0;
        ctrl.aluSrc    = 1'b0;
        ctrl.memRead   = 1'b0;
        ctrl.memWrite  = 1'b0;
        ctrl.memToReg  = 1'b0;
        ctrl.regDst    = DstRd;
        ctrl.signExt   = 1'b0;
        ctrl.jump      = 1'b0;
        ctrl.opIllegal = 1'b0;

        case (opcode)
            OpSpecial, OpSpecial2, OpSpecial3: begin
                ctrl.regWrite = 1'b1;  // Register operands, result to rd
                ctrl.regDst   = DstRd;
            end

            OpAddi, OpAddiu, OpSlti, OpSltiu: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.regDst   = DstRt;
                ctrl.signExt  = 1'b1;
            end

            OpAndi, OpOri, OpXori: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.regDst   = DstRt;
                ctrl.signExt  = 1'b0;  // Logic ops zero-extend
            end

            OpLb, OpLh, OpLw: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.regDst   = DstRt;
                ctrl.signExt  = 1'b1;  // Base plus signed offset
            end

            OpSb, OpSh, OpSw: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
                ctrl.regDst   = DstRt;
                ctrl.signExt  = 1'b1;
            end

            OpJ: begin
                ctrl.jump = 1'b1;
            end

            OpJal: begin
                ctrl.jump     = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.regDst   = DstLink;  // Return address into r31
            end

            default: begin
                ctrl.opIllegal = 1'b1;  // Branches, LUI and the rest
            end
        endcase

        // Access width for loads and stores
        case (opcode)
            OpLb, OpSb: ctrl.memSize = MemByte;
            OpLh, OpSh: ctrl.memSize = MemHalf;
            default:    ctrl.memSize = MemWord;
        endcase
    end

endmodule

/* rtl/ctrlBus.sv */
`timescale 1ns/1ps

interface ctrlBus;
    import decodePkg::*;

    logic     regWrite;
    logic     aluSrc;     // Second ALU operand is the immediate
    logic     memRead;
    logic     memWrite;
    logic     memToReg;   // Writeback from memory
    memSize_t memSize;
    regDst_t  regDst;
    logic     signExt;
    logic     jump;
    logic     opIllegal;  // Opcode not decoded

    modport source (
        output regWrite, aluSrc, memRead, memWrite, memToReg,
        output memSize, regDst, signExt, jump, opIllegal
    );

    modport sink (
        input regWrite, aluSrc, memRead, memWrite, memToReg,
        input memSize, regDst, signExt, jump, opIllegal
    );

endinterface

/* rtl/decodePkg.sv */
package decodePkg;

    // Primary opcodes, instr[31:26]
    localparam logic [5:0] OpSpecial  = 6'b000000;  // R-type
    localparam logic [5:0] OpJ        = 6'b000010;
    localparam logic [5:0] OpJal      = 6'b000011;
    localparam logic [5:0] OpAddi     = 6'b001000;
    localparam logic [5:0] OpAddiu    = 6'b001001;
    localparam logic [5:0] OpSlti     = 6'b001010;
    localparam logic [5:0] OpSltiu    = 6'b001011;
    localparam logic [5:0] OpAndi     = 6'b001100;
    localparam logic [5:0] OpOri      = 6'b001101;
    localparam logic [5:0] OpXori     = 6'b001110;
    localparam logic [5:0] OpSpecial2 = 6'b011100;  // MUL lives here
    localparam logic [5:0] OpSpecial3 = 6'b011111;  // SEB, SEH
    localparam logic [5:0] OpLb       = 6'b100000;
    localparam logic [5:0] OpLh       = 6'b100001;
    localparam logic [5:0] OpLw       = 6'b100011;
    localparam logic [5:0] OpSb       = 6'b101000;
    localparam logic [5:0] OpSh       = 6'b101001;
    localparam logic [5:0] OpSw       = 6'b101011;

    // R-type function codes, instr[5:0]
    localparam logic [5:0] FnSll   = 6'b000000;
    localparam logic [5:0] FnSrl   = 6'b000010;
    localparam logic [5:0] FnSra   = 6'b000011;
    localparam logic [5:0] FnAdd   = 6'b100000;
    localparam logic [5:0] FnAddu  = 6'b100001;
    localparam logic [5:0] FnSub   = 6'b100010;
    localparam logic [5:0] FnSubu  = 6'b100011;
    localparam logic [5:0] FnAnd   = 6'b100100;
    localparam logic [5:0] FnOr    = 6'b100101;
    localparam logic [5:0] FnXor   = 6'b100110;
    localparam logic [5:0] FnNor   = 6'b100111;
    localparam logic [5:0] FnSlt   = 6'b101010;
    localparam logic [5:0] FnSltu  = 6'b101011;
    localparam logic [5:0] FnMul   = 6'b000010;  // Under SPECIAL2
    localparam logic [5:0] FnBshfl = 6'b100000;  // Under SPECIAL3

    // BSHFL sub-codes carried in the shamt field
    localparam logic [4:0] SaSeb = 5'b10000;
    localparam logic [4:0] SaSeh = 5'b11000;

    localparam logic [4:0] LinkReg = 5'd31;  // JAL return address

    typedef enum logic [4:0] {
        AluAdd, AluAddu, AluSub, AluSubu,
        AluAnd, AluOr, AluXor, AluNor,
        AluSlt, AluSltu, AluSll, AluSrl,
        AluSra, AluMul, AluSeb, AluSeh
    } aluOp_t;

    typedef enum logic [1:0] {MemByte, MemHalf, MemWord} memSize_t;

    typedef enum logic [1:0] {DstRd, DstRt, DstLink} regDst_t;

endpackage
